/* vic_cfg.svh */
`ifndef VIC_CFG_SVH
`define VIC_CFG_SVH

// sys_clock cycles per cpu phi period
// half of it low, half high
`define PHI_DIV 32

// sys_clock cycles per serial bit on the mcu link
`define BAUD_DIV 16

// consecutive high cclk samples before the mcu is considered up
// cclk toggles while the mcu is still configuring the fpga
`define CCLK_STABLE 64

`endif

/* vic_pkg.sv */
package vic_pkg;

  // register map of the cut-down vic-ii
  localparam int NUM_REGS = 47;                 // standard regs 0x00..0x2e
  localparam logic [5:0] COLOR_FIRST = 6'h20;   // border color
  localparam logic [5:0] COLOR_LAST = 6'h2E;    // sprite 7 color
  localparam logic [5:0] CFG_ADDR = 6'h3F;      // extension reg, goes to the mcu

  // cpu bus as seen at the chip pins
  typedef struct packed {
    logic       ce;   // chip enable, low = selected
    logic       rw;   // high = read, low = write
    logic [5:0] adi;  // register address
    logic [7:0] dbi;  // write data from cpu
  } bus_req_t;

  // answer from the register file
  typedef struct packed {
    logic [7:0] dbo;           // read data
    logic       vic_write_db;  // vic drives the data bus
  } bus_resp_t;

  // one byte offered to the serial link
  typedef struct packed {
    logic [7:0] data;
    logic       valid;  // single cycle pulse
  } tx_msg_t;

endpackage

/* phi_gen.sv */
`timescale 1ns/1ns

`include "vic_cfg.svh"

module phi_gen (
  input  logic sys_clock,
  input  logic reset,
  output logic clk_phi,
  output logic phase_high,
  output logic access_strobe,
  output logic cpu_reset
);

  localparam int PW = $clog2(`PHI_DIV);        // phase counter width
  localparam int HALF = `PHI_DIV / 2;          // first high phase
  localparam int STROBE_PHASE = HALF + HALF / 2;  // middle of phi high

  logic [PW-1:0] phase;

  // phase counter, wraps once per phi period
  always_ff @(posedge sys_clock) begin
    if (reset) begin
      phase <= '0;
    end else if (phase == PW'(`PHI_DIV - 1)) begin
      phase <= '0;
    end else begin
      phase <= phase + 1'b1;
    end
  end

  assign phase_high = (phase >= PW'(HALF));        // second half of the period
  assign clk_phi = phase_high;                     // phi low first, then high
  assign access_strobe = (phase == PW'(STROBE_PHASE));  // cpu bus is settled here

  // cpu held in reset one cycle behind ours
  always_ff @(posedge sys_clock) begin
    cpu_reset <= reset;
  end

endmodule

/* vic_regs.sv */
`timescale 1ns/1ns

module vic_regs (
  input  logic                sys_clock,
  input  logic                reset,
  input  logic                access_strobe,
  input  logic                phase_high,
  input  vic_pkg::bus_req_t   bus_req,
  output vic_pkg::bus_resp_t  bus_resp,
  output vic_pkg::tx_msg_t    tx_msg
);

  logic [7:0] regs [vic_pkg::NUM_REGS];  // standard register file
  logic [7:0] cfg_reg;                   // extension register
  logic [7:0] dbo_q;                     // read data held for the bus
  logic       rd_active;                 // a read is in progress this phi high
  logic [7:0] tx_data_q;
  logic       tx_valid_q;

  // address classes
  logic is_std;
  logic is_color;
  logic is_cfg;

  // bus qualifiers, only valid while access_strobe is high
  logic bus_wr;
  logic bus_rd;

  logic [7:0] rd_val;

  assign is_std = (bus_req.adi < 6'(vic_pkg::NUM_REGS));
  assign is_color = (bus_req.adi >= vic_pkg::COLOR_FIRST) &&
                    (bus_req.adi <= vic_pkg::COLOR_LAST);  // subset of is_std
  assign is_cfg = (bus_req.adi == vic_pkg::CFG_ADDR);

  assign bus_wr = access_strobe && !bus_req.ce && !bus_req.rw;
  assign bus_rd = access_strobe && !bus_req.ce && bus_req.rw;

  // read mux
  always_comb begin
    rd_val = 8'hFF;  // unused addresses float high
    if (is_cfg) begin
      rd_val = cfg_reg;
    end else if (is_color) begin
      rd_val = {4'hF, regs[bus_req.adi][3:0]};  // upper nibble reads as ones
    end else if (is_std) begin
      rd_val = regs[bus_req.adi];
    end
  end

  // register writes
  always_ff @(posedge sys_clock) begin
    if (reset) begin
      for (int i = 0; i < vic_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
      cfg_reg <= '0;
    end else if (bus_wr) begin
      if (is_cfg) begin
        cfg_reg <= bus_req.dbi;
      end else if (is_color) begin
        regs[bus_req.adi] <= {4'h0, bus_req.dbi[3:0]};  // color regs are 4 bit
      end else if (is_std) begin
        regs[bus_req.adi] <= bus_req.dbi;
      end
      // 0x2f..0x3e fall through, write ignored
    end
  end

  // read data, loaded at the strobe and visible from the next phase
  always_ff @(posedge sys_clock) begin
    if (reset) begin
      dbo_q <= '0;
    end else if (bus_rd) begin
      dbo_q <= rd_val;  // held until the next read
    end
  end

  // data bus drive enable
  always_ff @(posedge sys_clock) begin
    if (reset) begin
      rd_active <= 1'b0;
    end else if (bus_rd) begin
      rd_active <= 1'b1;
    end else if (!phase_high) begin
      rd_active <= 1'b0;  // phi low, bus belongs to the cpu again
    end
  end

  // gate with phase_high so the enable drops exactly at the phi fall
  assign bus_resp.vic_write_db = rd_active && phase_high;
  assign bus_resp.dbo = dbo_q;

  // config byte offer to the serial link
  always_ff @(posedge sys_clock) begin
    if (reset) begin
      tx_valid_q <= 1'b0;
    end else begin
      tx_valid_q <= bus_wr && is_cfg;  // one cycle pulse per write
    end
  end

  always_ff @(posedge sys_clock) begin
    if (bus_wr && is_cfg) begin
      tx_data_q <= bus_req.dbi;
    end
  end

  assign tx_msg.data = tx_data_q;
  assign tx_msg.valid = tx_valid_q;

endmodule

/* avr_link.sv */
`timescale 1ns/1ns

`include "vic_cfg.svh"

module avr_link (
  input  logic              sys_clock,
  input  logic              reset,
  input  logic              cclk,
  input  vic_pkg::tx_msg_t  tx_msg,
  output logic              tx
);

  localparam int CW = $clog2(`CCLK_STABLE + 1);  // stability counter width
  localparam int BW = $clog2(`BAUD_DIV);         // baud counter width

  // cclk synchronizer and readiness
  logic          cclk_meta;
  logic          cclk_sync;
  logic [CW-1:0] stable_cnt;
  logic          link_ready;

  // pending byte
  logic          pend_full;
  logic [7:0]    pend_data;

  // transmitter
  logic          busy;
  logic [BW-1:0] baud_cnt;
  logic [3:0]    bit_cnt;   // 0 = start, 1..8 = data, 9 = stop
  logic [8:0]    shreg;     // data bits then stop bit, lsb goes out first
  logic          tx_q;
  logic          start;

  // two flop sync, cclk comes straight from the mcu
  always_ff @(posedge sys_clock) begin
    if (reset) begin
      cclk_meta <= 1'b0;
      cclk_sync <= 1'b0;
    end else begin
      cclk_meta <= cclk;
      cclk_sync <= cclk_meta;
    end
  end

  // count consecutive high samples
  always_ff @(posedge sys_clock) begin
    if (reset || !cclk_sync) begin
      stable_cnt <= '0;  // any low sample restarts the wait
      link_ready <= 1'b0;
    end else if (stable_cnt == CW'(`CCLK_STABLE)) begin
      link_ready <= 1'b1;  // counter parks here
    end else begin
      stable_cnt <= stable_cnt + 1'b1;
    end
  end

  assign start = !busy && link_ready && pend_full;

  // one entry buffer, newest byte wins
  always_ff @(posedge sys_clock) begin
    if (reset) begin
      pend_full <= 1'b0;
    end else if (tx_msg.valid) begin
      pend_full <= 1'b1;  // also covers an offer landing on the start cycle
    end else if (start) begin
      pend_full <= 1'b0;
    end
  end

  always_ff @(posedge sys_clock) begin
    if (tx_msg.valid) begin
      pend_data <= tx_msg.data;
    end
  end

  // 8n1 shifter
  always_ff @(posedge sys_clock) begin
    if (reset) begin
      busy <= 1'b0;
      baud_cnt <= '0;
      bit_cnt <= '0;
      tx_q <= 1'b1;  // line idles high
    end else if (start) begin
      busy <= 1'b1;
      baud_cnt <= '0;
      bit_cnt <= '0;
      tx_q <= 1'b0;  // start bit
    end else if (busy) begin
      if (baud_cnt == BW'(`BAUD_DIV - 1)) begin
        baud_cnt <= '0;
        if (bit_cnt == 4'd9) begin
          busy <= 1'b0;  // stop bit done, tx already high
        end else begin
          tx_q <= shreg[0];
          bit_cnt <= bit_cnt + 1'b1;
        end
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  // payload shift register
  always_ff @(posedge sys_clock) begin
    if (start) begin
      shreg <= {1'b1, pend_data};  // stop bit sits above the data
    end else if (busy && baud_cnt == BW'(`BAUD_DIV - 1)) begin
      shreg <= {1'b1, shreg[8:1]};
    end
  end

  assign tx = tx_q;

endmodule

/* vic_top.sv */
`timescale 1ns/1ns

module vic_top (
  input  logic       sys_clock,
  input  logic       reset,
  input  logic       ce,            // chip enable, active low
  input  logic       rw,            // high = read
  input  logic [5:0] adi,           // register address from cpu
  input  logic [7:0] dbl,           // data lines from cpu
  input  logic       cclk,          // from mcu, async
  output logic       clk_phi,       // phi clock to the cpu
  output logic       cpu_reset,     // reset for the 6510
  output logic [7:0] dbo,           // read data toward the data lines
  output logic       vic_write_db,  // enable for dbo on the data lines
  output logic       tx             // serial to mcu
);

  logic                phase_high;
  logic                access_strobe;
  vic_pkg::bus_req_t   bus_req;
  vic_pkg::bus_resp_t  bus_resp;
  vic_pkg::tx_msg_t    tx_msg;

  // pins into the request struct
  assign bus_req.ce = ce;
  assign bus_req.rw = rw;
  assign bus_req.adi = adi;
  assign bus_req.dbi = dbl;

  // sys_clock / 32 gives phi
  phi_gen u_phi_gen (
    .sys_clock     (sys_clock),
    .reset         (reset),
    .clk_phi       (clk_phi),
    .phase_high    (phase_high),
    .access_strobe (access_strobe),
    .cpu_reset     (cpu_reset)
  );

  // cpu register file
  vic_regs u_vic_regs (
    .sys_clock     (sys_clock),
    .reset         (reset),
    .access_strobe (access_strobe),
    .phase_high    (phase_high),
    .bus_req       (bus_req),
    .bus_resp      (bus_resp),
    .tx_msg        (tx_msg)
  );

  // config byte out to the mcu, same clock so no crossing needed
  avr_link u_avr_link (
    .sys_clock (sys_clock),
    .reset     (reset),
    .cclk      (cclk),
    .tx_msg    (tx_msg),
    .tx        (tx)
  );

  // response back onto the pins
  assign dbo = bus_resp.dbo;
  assign vic_write_db = bus_resp.vic_write_db;

endmodule

/* vic_checker.sv */
`timescale 1ns/1ns

`include "vic_cfg.svh"

module vic_checker (
  input  logic              sys_clock,
  input  logic              reset,
  input  vic_pkg::bus_req_t bus,
  input  logic [7:0]        exp_rd,
  input  logic              cclk,
  input  logic              clk_phi,
  input  logic              cpu_reset,
  input  logic [7:0]        dbo,
  input  logic              vic_write_db,
  input  logic              tx,
  input  logic              done,
  input  int                assert_fails,
  output int                errors,
  output logic              link_idle
);

  logic [7:0] model [vic_pkg::NUM_REGS];  // own copy of the register file
  logic [7:0] model_cfg = 8'h00;
  logic [7:0] last_cfg = 8'h00;  // newest byte waiting for the link
  logic read_cycle = 1'b0;
  logic in_frame = 1'b0;
  logic reset_d;
  int wr_seq = 0;     // cfg writes seen
  int taken_seq = 0;  // writes covered by a started frame
  int cclk_high = 0;
  int reads = 0;
  int frames = 0;
  int err_read = 0;
  int err_frame = 0;
  int err_enable = 0;
  int err_reset = 0;
  int err_final = 0;

  initial foreach (model[i]) model[i] = 8'h00;

  assign errors = err_read + err_frame + err_enable + err_reset + err_final + assert_fails;
  assign link_idle = (wr_seq == taken_seq) && !in_frame;

  function automatic logic [7:0] model_read(logic [5:0] a);
    if (a == vic_pkg::CFG_ADDR) return model_cfg;
    if (a >= vic_pkg::COLOR_FIRST && a <= vic_pkg::COLOR_LAST) return {4'hF, model[a][3:0]};
    if (a < 6'(vic_pkg::NUM_REGS)) return model[a];
    return 8'hFF;
  endfunction

  // bus inputs are stable through phi high
  always begin : sample_bus
    logic [7:0] exp;
    logic seen;
    @(posedge clk_phi);
    read_cycle = !reset && !bus.ce && bus.rw;
    if (!reset && !bus.ce && !bus.rw) begin
      if (bus.adi == vic_pkg::CFG_ADDR) begin
        model_cfg = bus.dbi;
        repeat (10) @(posedge sys_clock);  // dut buffer loads here
        #1;
        last_cfg = model_cfg;
        wr_seq = wr_seq + 1;
      end else if (bus.adi >= vic_pkg::COLOR_FIRST && bus.adi <= vic_pkg::COLOR_LAST) begin
        model[bus.adi] = {4'h0, bus.dbi[3:0]};
      end else if (bus.adi < 6'(vic_pkg::NUM_REGS)) begin
        model[bus.adi] = bus.dbi;
      end
    end else if (read_cycle) begin
      exp = model_read(bus.adi);
      if (exp !== exp_rd) begin
        $display("error at %0t ns: table expects %02h at %02h, model has %02h",
                 $time, exp_rd, bus.adi, exp);
        err_read = err_read + 1;
      end
      seen = 1'b0;
      for (int k = 0; k < 15 && !seen; k++) begin
        @(posedge sys_clock);
        #1;
        seen = vic_write_db;
      end
      if (!seen) begin
        $display("read of address %02h got no data bus enable", bus.adi);
        err_read = err_read + 1;
      end else if (dbo !== exp) begin
        $display("error at %0t ns: dbo %02h, expected %02h", $time, dbo, exp);
        err_read = err_read + 1;
      end
      reads = reads + 1;
    end
  end

  // enable only for a real read and never in phi low
  always @(posedge sys_clock) begin
    #1;
    if (vic_write_db && (!read_cycle || !clk_phi)) begin
      $display("data bus enable raised with no read in this phi high");
      err_enable = err_enable + 1;
    end
  end

  always @(posedge sys_clock) reset_d <= reset;

  always @(negedge sys_clock) begin
    if (!$isunknown(reset_d) && cpu_reset !== reset_d) begin
      $display("error at %0t ns: cpu_reset %b, expected %b", $time, cpu_reset, reset_d);
      err_reset = err_reset + 1;
    end
    if (reset_d === 1'b1 && clk_phi !== 1'b0) begin
      $display("error at %0t ns: clk_phi %b in reset, expected 0", $time, clk_phi);
      err_reset = err_reset + 1;
    end
  end

  always @(posedge sys_clock) cclk_high <= cclk ? cclk_high + 1 : 0;

  // 8n1 receiver sampling mid bit
  always begin : rx_frames
    logic [7:0] got;
    logic [7:0] want;
    logic wanted;
    @(negedge tx);
    in_frame = 1'b1;
    wanted = (wr_seq != taken_seq);
    want = last_cfg;
    taken_seq = wr_seq;
    if (cclk_high < `CCLK_STABLE) begin
      $display("frame started before cclk was stable");
      err_frame = err_frame + 1;
    end
    if (!wanted) begin
      $display("frame sent with no config byte pending");
      err_frame = err_frame + 1;
    end
    repeat (`BAUD_DIV / 2) @(posedge sys_clock);
    #1;
    if (tx !== 1'b0) begin
      $display("error at %0t ns: start bit not low", $time);
      err_frame = err_frame + 1;
    end
    for (int b = 0; b < 8; b++) begin
      repeat (`BAUD_DIV) @(posedge sys_clock);
      #1;
      got[b] = tx;  // lsb first
    end
    repeat (`BAUD_DIV) @(posedge sys_clock);
    #1;
    if (tx !== 1'b1) begin
      $display("error at %0t ns: stop bit not high", $time);
      err_frame = err_frame + 1;
    end
    if (wanted && got !== want) begin
      $display("error at %0t ns: frame byte %02h, expected %02h", $time, got, want);
      err_frame = err_frame + 1;
    end
    frames = frames + 1;
    in_frame = 1'b0;
  end

  always @(posedge done) begin : closing
    string line;
    if (wr_seq != taken_seq) begin
      $display("config byte %02h was written but never sent", last_cfg);
      err_final = err_final + 1;
    end
    line = $sformatf("checker: %0d reads, %0d frames,", reads, frames);
    line = {line, $sformatf(" errors read %0d enable %0d frame %0d",
                            err_read, err_enable, err_frame)};
    line = {line, $sformatf(" reset %0d end %0d assert %0d",
                            err_reset, err_final, assert_fails)};
    $display("%s", line);
  end

endmodule

/* vic_assertions.sv */
`timescale 1ns/1ns

module vic_assertions (
  input logic sys_clock,
  input logic reset,
  input logic clk_phi,
  input logic vic_write_db,
  input logic tx
);

  int fail_count = 0;  // assertion failures so far

  // data bus only driven in phi high
  a_db_in_phi_high: assert property (@(posedge sys_clock) !clk_phi |-> !vic_write_db)
    else begin
      $error("vic_write_db high while clk_phi low");
      fail_count = fail_count + 1;
    end

  // serial line idles high in reset
  a_tx_idle_in_reset: assert property (@(posedge sys_clock) (reset ##1 reset) |-> tx)
    else begin
      $error("tx low during reset");
      fail_count = fail_count + 1;
    end

  // half period of phi is 16 sys clocks
  a_phi_high_len: assert property (@(posedge sys_clock) disable iff (reset)
    $rose(clk_phi) |-> ##16 $fell(clk_phi))
    else begin
      $error("clk_phi high phase not 16 cycles");
      fail_count = fail_count + 1;
    end

  a_phi_low_len: assert property (@(posedge sys_clock) disable iff (reset)
    $fell(clk_phi) |-> ##16 $rose(clk_phi))
    else begin
      $error("clk_phi low phase not 16 cycles");
      fail_count = fail_count + 1;
    end

endmodule

bind vic_top vic_assertions u_assertions (
  .sys_clock    (sys_clock),
  .reset        (reset),
  .clk_phi      (clk_phi),
  .vic_write_db (vic_write_db),
  .tx           (tx)
);

/* vic_tb.sv */
`timescale 1ns/1ns

`include "vic_cfg.svh"

module vic_tb;

  // one table row per phi period on the bus
  typedef struct packed {
    logic       ce;
    logic       rw;
    logic [5:0] adr;
    logic [7:0] data;
    logic [7:0] exp;   // expected read value
  } entry_t;

  logic sys_clock;
  logic reset;
  logic cclk;
  logic done;
  logic table_ready;
  logic [7:0] exp_rd;
  vic_pkg::bus_req_t bus;
  logic clk_phi;
  logic cpu_reset;
  logic [7:0] dbo;
  logic vic_write_db;
  logic tx;
  int errors;
  logic link_idle;

  entry_t table_q[$];
  int seed;

  // value read back after writing d to address a
  function automatic logic [7:0] read_after_write(logic [5:0] a, logic [7:0] d);
    if (a == 6'h3F) return d;                     // config reg keeps the byte
    if (a >= 6'h20 && a <= 6'h2E) return {4'hF, d[3:0]};  // colors are 4 bit
    if (a < 6'd47) return d;
    return 8'hFF;                                 // unused reads high
  endfunction

  task automatic add_entry(logic ce, logic rw, logic [5:0] a, logic [7:0] d, logic [7:0] e);
    entry_t row;
    row = '{ce: ce, rw: rw, adr: a, data: d, exp: e};
    table_q.push_back(row);
  endtask

  task automatic build_table();
    logic [5:0] a;
    logic [7:0] d;
    add_entry(0, 0, 6'h00, 8'h12, 8'h00);
    add_entry(0, 0, 6'h11, 8'h1B, 8'h00);
    add_entry(0, 0, 6'h18, 8'h14, 8'h00);
    add_entry(0, 0, 6'h1F, 8'hA5, 8'h00);
    add_entry(0, 1, 6'h00, 8'h00, 8'h12);
    add_entry(0, 1, 6'h11, 8'h00, 8'h1B);
    add_entry(0, 1, 6'h18, 8'h00, 8'h14);
    add_entry(0, 1, 6'h1F, 8'h00, 8'hA5);
    add_entry(0, 0, 6'h20, 8'hAB, 8'h00);  // border color
    add_entry(0, 1, 6'h20, 8'h00, 8'hFB);
    add_entry(0, 0, 6'h2E, 8'h37, 8'h00);
    add_entry(0, 1, 6'h2E, 8'h00, 8'hF7);
    add_entry(0, 0, 6'h30, 8'h55, 8'h00);  // unused address drops the write
    add_entry(0, 1, 6'h30, 8'h00, 8'hFF);
    add_entry(0, 1, 6'h3E, 8'h00, 8'hFF);
    add_entry(1, 0, 6'h00, 8'h99, 8'h00);  // not selected
    add_entry(1, 1, 6'h00, 8'h00, 8'h00);
    add_entry(0, 1, 6'h00, 8'h00, 8'h12);  // still the old byte
    add_entry(0, 0, 6'h3F, 8'hC3, 8'h00);  // queued while cclk is low
    add_entry(0, 1, 6'h3F, 8'h00, 8'hC3);
    for (int i = 0; i < 10; i++) begin
      a = 6'(1 + ($unsigned($random(seed)) % 46));  // keeps reg 0 intact
      d = 8'($random(seed));
      add_entry(0, 0, a, d, 8'h00);
      add_entry(0, 1, a, 8'h00, read_after_write(a, d));
    end
    for (int i = 0; i < 3; i++) begin
      add_entry(0, 1, 6'h00, 8'h00, 8'h12);  // first frame starts
    end
    add_entry(0, 0, 6'h3F, 8'h5A, 8'h00);  // three writes during one frame
    add_entry(0, 0, 6'h3F, 8'h66, 8'h00);
    add_entry(0, 0, 6'h3F, 8'h81, 8'h00);
    add_entry(0, 1, 6'h3F, 8'h00, 8'h81);
    for (int i = 0; i < 4; i++) begin
      add_entry(0, 1, 6'h00, 8'h00, 8'h12);
    end
  endtask

  vic_top DUT (
    .sys_clock    (sys_clock),
    .reset        (reset),
    .ce           (bus.ce),
    .rw           (bus.rw),
    .adi          (bus.adi),
    .dbl          (bus.dbi),
    .cclk         (cclk),
    .clk_phi      (clk_phi),
    .cpu_reset    (cpu_reset),
    .dbo          (dbo),
    .vic_write_db (vic_write_db),
    .tx           (tx)
  );

  vic_checker u_checker (
    .sys_clock    (sys_clock),
    .reset        (reset),
    .bus          (bus),
    .exp_rd       (exp_rd),
    .cclk         (cclk),
    .clk_phi      (clk_phi),
    .cpu_reset    (cpu_reset),
    .dbo          (dbo),
    .vic_write_db (vic_write_db),
    .tx           (tx),
    .done         (done),
    .assert_fails (DUT.u_assertions.fail_count),
    .errors       (errors),
    .link_idle    (link_idle)
  );

  initial begin
    sys_clock = 1'b0;
    forever #20 sys_clock = ~sys_clock;  // 25 MHz
  end

  // watchdog covers every entry plus a few frames of slack
  initial begin
    wait (table_ready);
    #((table_q.size() + 2) * `PHI_DIV * 40 + 4 * 10 * `BAUD_DIV * 40 + 8 * 40);
    $display("timeout: run did not finish, serial link or bus stuck");
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    reset = 1'b1;
    cclk = 1'b0;
    done = 1'b0;
    table_ready = 1'b0;
    exp_rd = 8'h00;
    bus = '{ce: 1'b1, rw: 1'b1, adi: 6'h00, dbi: 8'h00};  // bus idle
    seed = 32'he9f14660;
    build_table();
    table_ready = 1'b1;
    repeat (8) @(posedge sys_clock);
    #2 reset = 1'b0;
    foreach (table_q[i]) begin
      @(negedge clk_phi);
      @(posedge sys_clock);
      #2;
      if (i == 40) cclk = 1'b1;  // mcu done configuring
      bus = '{ce: table_q[i].ce, rw: table_q[i].rw, adi: table_q[i].adr, dbi: table_q[i].data};
      exp_rd = table_q[i].exp;
    end
    @(negedge clk_phi);
    @(posedge sys_clock);
    #2 bus.ce = 1'b1;
    wait (link_idle);  // last frame out
    repeat (10) @(posedge sys_clock);
    done = 1'b1;
    #1;
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+.
vic_pkg.sv
phi_gen.sv
vic_regs.sv
avr_link.sv
vic_top.sv
vic_checker.sv
vic_assertions.sv
vic_tb.sv

/* run.sh */
#!/bin/sh
# build and run with verilator, pass only if the pass message shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module vic_tb -f filelist.f -o vic_sim &&
out="$(./obj_dir/vic_sim)" &&
echo "$out" &&
echo "$out" | grep -qF "*** TEST PASSED ***" ||
{ echo "simulation failed"; exit 1; }
